//--- rate_loop_top.f
trig_bus_pkg.sv
rate_loop_pkg.sv
trig_req_if.sv
loop_reg_target.sv
rate_loop_sequencer.sv
trig_bus_master.sv
rate_loop_top.sv
rate_loop_properties.sv
rate_loop_checker.sv
tb_rate_loop.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rate loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rate_loop \
    -f rate_loop_top.f \
    -o sim_rate_loop
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_rate_loop)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- tb_rate_loop.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rate_loop;
    import trig_bus_pkg::*;
    import rate_loop_pkg::*;

    localparam int NLOOPS   = 4;
    localparam int TXN_MAX  = 8;                      // req, strobe, 3 wait cycles, ack, done
    localparam int LOOP_MAX = 11 * TXN_MAX + NBEAMS;  // Transactions per loop plus CALC
    localparam int WATCHDOG = (BOOT_DELAY + 5 * LOOP_MAX + 200) * 10;

    logic     wb_clk_i = 1'b0;
    logic     arst_n_i;
    logic     wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    bus_adr_t wb_adr_i;
    bus_dat_t wb_dat_i, wb_dat_o;
    logic     trig_stb_o, trig_we_o, trig_ack_i;
    bus_adr_t trig_adr_o;
    bus_dat_t trig_dat_o, trig_dat_i;
    logic     chk_done;
    int       chk_errors;

    count_t   model_counts [NBEAMS];
    int       ack_delay;
    logic     ack_armed;
    int       poll_cnt;
    event     period_started;

    always #5 wb_clk_i = ~wb_clk_i;

    rate_loop_top dut_i (
        .wb_clk_i (wb_clk_i), .arst_n_i (arst_n_i),
        .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
        .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
        .wb_ack_o (wb_ack_o), .wb_dat_o (wb_dat_o),
        .trig_stb_o (trig_stb_o), .trig_we_o (trig_we_o),
        .trig_adr_o (trig_adr_o), .trig_dat_o (trig_dat_o),
        .trig_ack_i (trig_ack_i), .trig_dat_i (trig_dat_i)
    );

    rate_loop_checker #(.NLOOPS(NLOOPS)) u_checker (
        .wb_clk_i (wb_clk_i), .arst_n_i (arst_n_i),
        .trig_stb_i (trig_stb_o), .trig_we_i (trig_we_o), .trig_adr_i (trig_adr_o),
        .trig_wdat_i (trig_dat_o), .trig_ack_i (trig_ack_i), .trig_rdat_i (trig_dat_i),
        .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_adr_i (wb_adr_i),
        .wb_ack_i (wb_ack_o), .wb_dat_i (wb_dat_o),
        .done_o (chk_done), .errors_o (chk_errors)
    );

    bind rate_loop_top rate_loop_properties u_props (
        .wb_clk_i (wb_clk_i), .arst_n_i (arst_n_i),
        .trig_stb_i (trig_stb_o), .trig_adr_i (trig_adr_o),
        .trig_ack_i (trig_ack_i), .wb_ack_i (wb_ack_o)
    );

    // Above, inside or below the dead band and now and then at the extremes
    function automatic count_t pick_count();
        case ($urandom % 4)
            0:       return count_t'(111 + $urandom % 500);
            1:       return count_t'(90 + $urandom % 21);
            2:       return count_t'($urandom % 90);
            default: return ($urandom % 2) ? 32'hFFFF_FFFF : 32'h0;
        endcase
    endfunction

    ////////////////////
    // Trigger register model
    always @(negedge wb_clk_i) begin
        if (trig_ack_i) begin
            trig_ack_i <= 1'b0;  // Strobe has dropped by now
        end else if (trig_stb_o) begin
            if (!ack_armed) begin
                ack_delay = $urandom % 4;
                ack_armed = 1'b1;
            end
            if (ack_delay == 0) begin
                ack_armed = 1'b0;
                trig_ack_i <= 1'b1;
                if (trig_we_o) begin
                    if (trig_adr_o == CTRL_ADR && trig_dat_o == CMD_START_COUNT) begin
                        poll_cnt = 0;
                        for (int b = 0; b < NBEAMS; b++) model_counts[b] = pick_count();
                        -> period_started;
                    end
                end else if (trig_adr_o == CTRL_ADR) begin
                    poll_cnt++;
                    trig_dat_i <= (poll_cnt == 3) ? 32'd1 : 32'd0;  // Done on third poll
                end else begin
                    trig_dat_i <= bus_dat_t'(model_counts[(trig_adr_o - COUNT_BASE) >> 2]);
                end
            end else begin
                ack_delay--;
            end
        end
    end

    task automatic host_read(bus_adr_t adr);
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_adr_i = adr;
        do @(posedge wb_clk_i); while (!wb_ack_o);
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    // Host reads while the trigger is counting
    initial begin
        forever begin
            @(period_started);
            repeat (2) begin
                case ($urandom % 3)
                    0:       host_read(22'h400 | 22'(($urandom % 3) << 2));
                    1:       host_read(22'h800 | 22'(($urandom % 3) << 2));
                    default: host_read(22'h000);
                endcase
            end
        end
    end

    initial begin
        void'($urandom(32'h9b70_25fa));
        arst_n_i   = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        trig_ack_i = 1'b0;
        trig_dat_i = '0;
        ack_armed  = 1'b0;
        ack_delay  = 0;
        poll_cnt   = 0;
        for (int b = 0; b < NBEAMS; b++) model_counts[b] = '0;
        repeat (2) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        arst_n_i = 1'b1;
        wait (chk_done);
        @(posedge wb_clk_i);
        if (chk_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG);
        $display("Timeout: the control loop stopped making progress on the trigger bus");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rate_loop_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rate_loop_checker #(
    parameter int NLOOPS = 4
) (
    input  wire logic                   wb_clk_i,
    input  wire logic                   arst_n_i,
    input  wire logic                   trig_stb_i,
    input  wire logic                   trig_we_i,
    input  wire trig_bus_pkg::bus_adr_t trig_adr_i,
    input  wire trig_bus_pkg::bus_dat_t trig_wdat_i,
    input  wire logic                   trig_ack_i,
    input  wire trig_bus_pkg::bus_dat_t trig_rdat_i,
    input  wire logic                   wb_cyc_i,
    input  wire logic                   wb_stb_i,
    input  wire trig_bus_pkg::bus_adr_t wb_adr_i,
    input  wire logic                   wb_ack_i,
    input  wire trig_bus_pkg::bus_dat_t wb_dat_i,
    output logic                        done_o,
    output int                          errors_o
);
    import trig_bus_pkg::*;
    import rate_loop_pkg::*;

    int      n_checks;
    int      n_tests;
    int      test_err;
    int      host_wait;
    thresh_t exp_thresh [NBEAMS];  // Applied thresholds as the host should see them
    count_t  exp_counts [NBEAMS];

    // Reference step in wide signed arithmetic with clipping at both ends
    function automatic thresh_t next_thresh(thresh_t cur, count_t cnt);
        longint v;
        v = longint'(cur);
        if (longint'(cnt) > longint'(TARGET_COUNT) + longint'(COUNT_MARGIN))
            v = v + longint'(LOOP_KP);
        else if (longint'(cnt) < longint'(TARGET_COUNT) - longint'(COUNT_MARGIN))
            v = v - longint'(LOOP_KP);
        if (v < 0) v = 0;
        if (v > (longint'(1) << THRESH_W) - 1) v = (longint'(1) << THRESH_W) - 1;
        return thresh_t'(v);
    endfunction

    task automatic check_val(string name, bus_dat_t exp_v, bus_dat_t act_v);
        n_checks++;
        if (exp_v !== act_v) begin
            errors_o++;
            test_err++;
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp_v, act_v);
        end
    endtask

    task automatic finish_test(string name);
        n_tests++;
        $display("%s: %s", name, (test_err == 0) ? "ok" : "mismatch");
        test_err = 0;
    endtask

    // Waits for the next completed trigger transaction and samples it on the ack edge
    task automatic get_txn(output logic we, output bus_adr_t adr, output bus_dat_t dat);
        do @(posedge wb_clk_i); while (!(trig_stb_i && trig_ack_i));
        we  = trig_we_i;
        adr = trig_adr_i;
        dat = trig_we_i ? trig_wdat_i : trig_rdat_i;
    endtask

    task automatic expect_write(string name, bus_adr_t adr, bus_dat_t dat);
        logic     we;
        bus_adr_t a;
        bus_dat_t d;
        get_txn(we, a, d);
        check_val({name, " we"}, 32'd1, bus_dat_t'(we));
        check_val({name, " adr"}, bus_dat_t'(adr), bus_dat_t'(a));
        check_val({name, " data"}, dat, d);
    endtask

    task automatic expect_read(string name, bus_adr_t adr, output bus_dat_t dat);
        logic     we;
        bus_adr_t a;
        get_txn(we, a, dat);
        check_val({name, " we"}, 32'd0, bus_dat_t'(we));
        check_val({name, " adr"}, bus_dat_t'(adr), bus_dat_t'(a));
    endtask

    ////////////////////
    // Trigger transaction sequence
    initial begin
        string    name;
        bus_dat_t dat;
        int       polls;
        count_t   seen [NBEAMS];
        thresh_t  nxt [NBEAMS];
        done_o   = 1'b0;
        errors_o = 0;
        n_checks = 0;
        n_tests  = 0;
        test_err = 0;
        for (int b = 0; b < NBEAMS; b++) begin
            exp_thresh[b] = START_THRESH;
            exp_counts[b] = '0;
        end
        @(posedge arst_n_i);
        for (int b = 0; b < NBEAMS; b++)
            expect_write($sformatf("boot thresh beam%0d", b), COUNT_BASE + 22'(4 * b),
                         bus_dat_t'(START_THRESH));
        for (int b = 0; b < NBEAMS; b++)
            expect_write($sformatf("boot enable beam%0d", b), ENABLE_BASE + 22'(4 * b),
                         CMD_ENABLE);
        expect_write("boot update", CTRL_ADR, CMD_UPDATE_ALL);
        finish_test("boot_writes");

        for (int l = 1; l <= NLOOPS; l++) begin
            name = $sformatf("loop%0d", l);
            expect_write({name, " start"}, CTRL_ADR, CMD_START_COUNT);
            polls = 0;
            do begin
                expect_read({name, " poll"}, CTRL_ADR, dat);
                polls++;
            end while (!dat[STATUS_DONE_BIT] && polls < 8);
            check_val({name, " polls"}, 32'd3, bus_dat_t'(polls));
            for (int b = 0; b < NBEAMS; b++) begin
                expect_read($sformatf("%s count beam%0d", name, b), COUNT_BASE + 22'(4 * b), dat);
                seen[b] = count_t'(dat);
                nxt[b]  = next_thresh(exp_thresh[b], seen[b]);
            end
            for (int b = 0; b < NBEAMS; b++)
                expect_write($sformatf("%s thresh beam%0d", name, b), COUNT_BASE + 22'(4 * b),
                             bus_dat_t'(nxt[b]));
            for (int b = 0; b < NBEAMS; b++)
                expect_write($sformatf("%s enable beam%0d", name, b), ENABLE_BASE + 22'(4 * b),
                             CMD_ENABLE);
            expect_write({name, " update"}, CTRL_ADR, CMD_UPDATE_ALL);
            for (int b = 0; b < NBEAMS; b++) begin
                exp_thresh[b] = nxt[b];
                exp_counts[b] = seen[b];
            end
            finish_test(name);
        end
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors_o);
        done_o = 1'b1;
    end

    ////////////////////
    // Host readback and ack latency
    always @(posedge wb_clk_i) begin
        int       idx;
        bus_dat_t exp_v;
        if (!arst_n_i) begin
            host_wait = -1;
        end else begin
            if (host_wait >= 0) host_wait++;  // Cycles since the request was first seen
            if (wb_ack_i) begin
                idx   = int'(wb_adr_i[HOST_IDX_MSB:HOST_IDX_LSB]);
                exp_v = '0;
                if (wb_adr_i[HOST_SEL_COUNT_BIT]) begin
                    if (idx < NBEAMS) exp_v = bus_dat_t'(exp_counts[idx]);
                end else if (wb_adr_i[HOST_SEL_THRESH_BIT]) begin
                    if (idx < NBEAMS) exp_v = bus_dat_t'(exp_thresh[idx]);
                end else begin
                    exp_v = bus_dat_t'(LOOP_KP);
                end
                n_tests++;
                n_checks++;
                if (host_wait != 2) begin
                    errors_o++;
                    $display("Host ack came %0d cycles after the request instead of 2",
                             host_wait);
                end
                if (wb_dat_i !== exp_v) begin
                    errors_o++;
                    $display("FAIL host_read 0x%06h expected 0x%08h actual 0x%08h",
                             wb_adr_i, exp_v, wb_dat_i);
                end else begin
                    $display("host_read 0x%06h: ok", wb_adr_i);
                end
                host_wait = -1;
            end else if (host_wait < 0 && wb_cyc_i && wb_stb_i) begin
                host_wait = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rate_loop_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rate_loop_properties (
    input wire logic                   wb_clk_i,
    input wire logic                   arst_n_i,
    input wire logic                   trig_stb_i,
    input wire trig_bus_pkg::bus_adr_t trig_adr_i,
    input wire logic                   trig_ack_i,
    input wire logic                   wb_ack_i
);

    ////////////////////
    // Trigger master bus
    a_stb_hold: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        trig_stb_i && !trig_ack_i |=> trig_stb_i && $stable(trig_adr_i))
        else $error("trigger strobe or address changed before the ack");

    a_stb_drop: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        trig_stb_i && trig_ack_i |=> !trig_stb_i)
        else $error("trigger strobe still high after the ack");

    // Host side ack is a single pulse
    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        wb_ack_i |=> !wb_ack_i)
        else $error("host ack held for two cycles");

endmodule

`default_nettype wire

//--- rate_loop_top.sv
`timescale 1ns/1ps
`default_nettype none

module rate_loop_top (
    input  logic                   wb_clk_i,
    input  logic                   arst_n_i,
    // Host Wishbone target
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  trig_bus_pkg::bus_adr_t wb_adr_i,
    input  trig_bus_pkg::bus_dat_t wb_dat_i,  // Host writes have no register behind them
    output logic                   wb_ack_o,
    output trig_bus_pkg::bus_dat_t wb_dat_o,
    // Trigger register block master
    output logic                   trig_stb_o,
    output logic                   trig_we_o,
    output trig_bus_pkg::bus_adr_t trig_adr_o,
    output trig_bus_pkg::bus_dat_t trig_dat_o,
    input  logic                   trig_ack_i,
    input  trig_bus_pkg::bus_dat_t trig_dat_i
);
    import rate_loop_pkg::*;

    count_arr_t  count_arr;
    thresh_arr_t thresh_arr;

    trig_req_if req_bus ();

    loop_reg_target u_reg_target (
        .wb_clk_i     (wb_clk_i),
        .arst_n_i     (arst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o),
        .count_arr_i  (count_arr),
        .thresh_arr_i (thresh_arr)
    );

    rate_loop_sequencer u_sequencer (
        .wb_clk_i     (wb_clk_i),
        .arst_n_i     (arst_n_i),
        .req_o        (req_bus.seq_mp),
        .count_arr_o  (count_arr),
        .thresh_arr_o (thresh_arr)
    );

    trig_bus_master u_bus_master (
        .wb_clk_i   (wb_clk_i),
        .arst_n_i   (arst_n_i),
        .req_i      (req_bus.master_mp),
        .trig_stb_o (trig_stb_o),
        .trig_we_o  (trig_we_o),
        .trig_adr_o (trig_adr_o),
        .trig_dat_o (trig_dat_o),
        .trig_ack_i (trig_ack_i),
        .trig_dat_i (trig_dat_i)
    );

endmodule

`default_nettype wire

//--- trig_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module trig_bus_master (
    input  logic                   wb_clk_i,
    input  logic                   arst_n_i,
    trig_req_if.master_mp          req_i,
    output logic                   trig_stb_o,
    output logic                   trig_we_o,
    output trig_bus_pkg::bus_adr_t trig_adr_o,
    output trig_bus_pkg::bus_dat_t trig_dat_o,
    input  logic                   trig_ack_i,
    input  trig_bus_pkg::bus_dat_t trig_dat_i
);
    import trig_bus_pkg::*;

    typedef enum logic {M_IDLE, M_BUSY} master_state_e;

    master_state_e state;
    logic          done_q;
    logic          we_q;
    bus_adr_t      adr_q;
    bus_dat_t      wdat_q;
    bus_dat_t      rdat_q;

    ////////////////////
    // Single transaction FSM
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state  <= M_IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                M_IDLE: if (req_i.req) state <= M_BUSY;  // Strobe rises next cycle
                M_BUSY: begin
                    if (trig_ack_i) begin
                        state  <= M_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // Request fields held for the whole strobe
    always_ff @(posedge wb_clk_i) begin
        if (state == M_IDLE && req_i.req) begin
            we_q   <= req_i.we;
            adr_q  <= req_i.adr;
            wdat_q <= req_i.wdat;
        end
        if (state == M_BUSY && trig_ack_i && !we_q) rdat_q <= trig_dat_i;
    end

    assign trig_stb_o = (state == M_BUSY);
    assign trig_we_o  = we_q;
    assign trig_adr_o = adr_q;
    assign trig_dat_o = wdat_q;
    assign req_i.done = done_q;
    assign req_i.rdat = rdat_q;

endmodule

`default_nettype wire

//--- rate_loop_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rate_loop_sequencer (
    input  logic                       wb_clk_i,
    input  logic                       arst_n_i,
    trig_req_if.seq_mp                 req_o,
    output rate_loop_pkg::count_arr_t  count_arr_o,
    output rate_loop_pkg::thresh_arr_t thresh_arr_o
);
    import trig_bus_pkg::*;
    import rate_loop_pkg::*;

    loop_state_e           state;
    loop_state_e           phase_next;  // Where a per-beam phase goes after the last beam
    beam_idx_t             beam;
    logic                  last_beam;
    logic                  beam_step;
    logic                  busy;        // Transaction outstanding at the master
    logic [BOOT_CNT_W-1:0] boot_cnt;

    count_arr_t  counts;
    thresh_arr_t pending;  // CALC results, written to the trigger
    thresh_arr_t applied;  // Committed by the update command

    logic     needs_bus;
    logic     iss_we;
    bus_adr_t iss_adr;
    bus_dat_t iss_wdat;
    bus_adr_t beam_ofs;

    // One proportional step with saturation at both ends
    function automatic thresh_t calc_step(thresh_t cur, count_t cnt);
        thresh_t nxt;
        nxt = cur;
        if (cnt > TARGET_COUNT + COUNT_MARGIN) begin
            nxt = (cur > THRESH_MAX - LOOP_KP) ? THRESH_MAX : cur + LOOP_KP;
        end else if (cnt < TARGET_COUNT - COUNT_MARGIN) begin
            nxt = (cur < LOOP_KP) ? '0 : cur - LOOP_KP;
        end
        return nxt;
    endfunction

    assign beam_ofs  = bus_adr_t'(beam) * ADR_STRIDE;
    assign last_beam = (beam == beam_idx_t'(NBEAMS - 1));

    ////////////////////
    // Transaction for the current state
    always_comb begin
        needs_bus  = 1'b1;
        iss_we     = 1'b1;
        iss_adr    = CTRL_ADR;
        iss_wdat   = '0;
        beam_step  = 1'b0;
        phase_next = state;
        case (state)
            START: iss_wdat = CMD_START_COUNT;
            POLL:  iss_we = 1'b0;
            READ_COUNTS: begin
                iss_we     = 1'b0;
                iss_adr    = COUNT_BASE + beam_ofs;
                beam_step  = req_o.done;
                phase_next = CALC;
            end
            CALC: begin
                needs_bus  = 1'b0;
                beam_step  = 1'b1;  // One beam per cycle
                phase_next = WRITE_THRESH;
            end
            WRITE_THRESH: begin
                iss_adr    = COUNT_BASE + beam_ofs;
                iss_wdat   = bus_dat_t'(pending[beam]);
                beam_step  = req_o.done;
                phase_next = ENABLE;
            end
            ENABLE: begin
                iss_adr    = ENABLE_BASE + beam_ofs;
                iss_wdat   = CMD_ENABLE;
                beam_step  = req_o.done;
                phase_next = UPDATE;
            end
            UPDATE:  iss_wdat = CMD_UPDATE_ALL;
            default: needs_bus = 1'b0;  // BOOT
        endcase
    end

    assign req_o.we   = iss_we;
    assign req_o.adr  = iss_adr;
    assign req_o.wdat = iss_wdat;

    ////////////////////
    // Loop FSM
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state     <= BOOT;
            beam      <= '0;
            busy      <= 1'b0;
            boot_cnt  <= '0;
            req_o.req <= 1'b0;
            counts    <= '0;
            pending   <= {NBEAMS{START_THRESH}};
            applied   <= {NBEAMS{START_THRESH}};
        end else begin
            req_o.req <= 1'b0;
            if (needs_bus && !busy) begin
                req_o.req <= 1'b1;
                busy      <= 1'b1;
            end
            if (req_o.done) busy <= 1'b0;

            if (beam_step) begin
                beam <= last_beam ? '0 : beam + 1'b1;
                if (last_beam) state <= phase_next;
            end

            case (state)
                BOOT: begin
                    if (boot_cnt == BOOT_CNT_W'(BOOT_DELAY - 1)) state <= WRITE_THRESH;
                    else boot_cnt <= boot_cnt + 1'b1;
                end
                START: if (req_o.done) state <= POLL;
                POLL:  if (req_o.done && req_o.rdat[STATUS_DONE_BIT]) state <= READ_COUNTS;
                READ_COUNTS: if (req_o.done) counts[beam] <= count_t'(req_o.rdat);
                CALC: pending[beam] <= calc_step(applied[beam], counts[beam]);
                UPDATE: begin
                    if (req_o.done) begin
                        applied <= pending;
                        state   <= START;
                    end
                end
                default: ;
            endcase
        end
    end

    assign count_arr_o  = counts;
    assign thresh_arr_o = applied;

endmodule

`default_nettype wire

//--- loop_reg_target.sv
`timescale 1ns/1ps
`default_nettype none

module loop_reg_target (
    input  logic                       wb_clk_i,
    input  logic                       arst_n_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  trig_bus_pkg::bus_adr_t     wb_adr_i,
    output logic                       wb_ack_o,
    output trig_bus_pkg::bus_dat_t     wb_dat_o,
    input  rate_loop_pkg::count_arr_t  count_arr_i,
    input  rate_loop_pkg::thresh_arr_t thresh_arr_i
);
    import trig_bus_pkg::*;
    import rate_loop_pkg::*;

    host_state_e state;
    bus_dat_t    resp_q;
    bus_dat_t    sel_count;
    bus_dat_t    sel_thresh;
    logic [HOST_IDX_MSB-HOST_IDX_LSB:0] host_idx;

    assign host_idx = wb_adr_i[HOST_IDX_MSB:HOST_IDX_LSB];

    // Beam select, out of range index reads as zero
    always_comb begin
        sel_count  = '0;
        sel_thresh = '0;
        for (int b = 0; b < NBEAMS; b++) begin
            if (int'(host_idx) == b) begin
                sel_count  = bus_dat_t'(count_arr_i[b]);
                sel_thresh = bus_dat_t'(thresh_arr_i[b]);
            end
        end
    end

    ////////////////////
    // Host access FSM
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:        if (wb_cyc_i && wb_stb_i) state <= wb_we_i ? WRITE : READ;
                READ, WRITE: state <= ACK;  // Writes carry no register effect
                default:     state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state == READ) begin
            if (wb_adr_i[HOST_SEL_COUNT_BIT])       resp_q <= sel_count;
            else if (wb_adr_i[HOST_SEL_THRESH_BIT]) resp_q <= sel_thresh;
            else                                    resp_q <= bus_dat_t'(LOOP_KP);
        end
    end

    assign wb_ack_o = (state == ACK);
    assign wb_dat_o = resp_q;  // Valid through ACK

endmodule

`default_nettype wire

//--- trig_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface trig_req_if;
    import trig_bus_pkg::*;

    logic     req;   // One-cycle pulse, fields valid with it
    logic     we;
    bus_adr_t adr;
    bus_dat_t wdat;
    logic     done;  // One-cycle pulse after the trigger ack
    bus_dat_t rdat;  // Held until the next read completes

    modport seq_mp (output req, we, adr, wdat, input done, rdat);

    modport master_mp (input req, we, adr, wdat, output done, rdat);

endinterface

`default_nettype wire

//--- rate_loop_pkg.sv
`default_nettype none

package rate_loop_pkg;

    localparam int NBEAMS     = 2;
    localparam int THRESH_W   = 18;
    localparam int COUNT_W    = 32;
    localparam int BEAM_IDX_W = $clog2(NBEAMS + 1);

    typedef logic [THRESH_W-1:0]             thresh_t;
    typedef logic [COUNT_W-1:0]              count_t;
    typedef logic [NBEAMS-1:0][THRESH_W-1:0] thresh_arr_t;
    typedef logic [NBEAMS-1:0][COUNT_W-1:0]  count_arr_t;
    typedef logic [BEAM_IDX_W-1:0]           beam_idx_t;

    ////////////////////
    // Loop constants
    localparam thresh_t START_THRESH = 18'd3500;
    localparam thresh_t THRESH_MAX   = '1;      // Full scale
    localparam thresh_t LOOP_KP      = 18'd2;   // Step per period
    localparam count_t  TARGET_COUNT = 32'd100;
    localparam count_t  COUNT_MARGIN = 32'd10;  // Dead band half width
    localparam int      BOOT_DELAY   = 31;
    localparam int      BOOT_CNT_W   = $clog2(BOOT_DELAY + 1);

    typedef enum logic [2:0] {
        BOOT, START, POLL, READ_COUNTS, CALC, WRITE_THRESH, ENABLE, UPDATE
    } loop_state_e;

    typedef enum logic [1:0] {IDLE, READ, WRITE, ACK} host_state_e;

endpackage

`default_nettype wire

//--- trig_bus_pkg.sv
`default_nettype none

package trig_bus_pkg;

    localparam int ADR_W = 22;
    localparam int DAT_W = 32;

    typedef logic [ADR_W-1:0] bus_adr_t;
    typedef logic [DAT_W-1:0] bus_dat_t;

    // Trigger register map
    localparam bus_adr_t CTRL_ADR    = 22'h000;  // Command on write, status on read
    localparam bus_adr_t COUNT_BASE  = 22'h400;  // Count on read, threshold on write
    localparam bus_adr_t ENABLE_BASE = 22'h800;
    localparam bus_adr_t ADR_STRIDE  = 22'd4;    // One word per beam

    localparam bus_dat_t CMD_START_COUNT = 32'd1;
    localparam bus_dat_t CMD_UPDATE_ALL  = 32'd2;
    localparam bus_dat_t CMD_ENABLE      = 32'd1;
    localparam int       STATUS_DONE_BIT = 0;

    // Host address decode
    localparam int HOST_SEL_COUNT_BIT  = 10;
    localparam int HOST_SEL_THRESH_BIT = 11;
    localparam int HOST_IDX_LSB        = 2;
    localparam int HOST_IDX_MSB        = 9;

endpackage

`default_nettype wire
